/* Bender.yml */
package:
  name: accel_display

sources:
  # Design sources in compile order
  - files:
      - common/accel_pkg.sv
      - accel_spi/accel_spi_master.sv
      - accel_spi/accel_reader.sv
      - rtl/seg7_control.sv
      - rtl/accel_display_top.sv

  # Simulation only
  - target: test
    files:
      - bench/adxl362_model.sv
      - bench/tb_accel_display.sv

/* accel_spi/accel_reader.sv */
`timescale 1ns/1ns
`default_nettype none

module accel_reader #(
    parameter int SAMPLE_CYCLES = 10_000_000
) (
    input  wire                   CLK100MHZ,
    input  wire                   rst_n,
    input  wire                   byte_done,
    input  wire accel_pkg::spi_byte_t rx_byte,
    output logic                  byte_start,
    output accel_pkg::spi_byte_t  tx_byte,
    output logic                  csn,
    output accel_pkg::accel_mag_t x_mag,
    output accel_pkg::accel_mag_t y_mag,
    output accel_pkg::accel_mag_t z_mag
);
    import accel_pkg::*;

    typedef enum logic [2:0] {
        ST_CONFIG,
        ST_GAP,
        ST_WAIT,
        ST_READ,
        ST_UPDATE
    } state_t;

    localparam int SW = (SAMPLE_CYCLES > 1) ? $clog2(SAMPLE_CYCLES) : 1;

    state_t        state;
    logic [2:0]    byte_idx;     // Position within the current transaction
    logic          in_flight;    // A byte is on the bus
    logic          last_byte;
    logic          sample_tick;
    logic [SW-1:0] sample_cnt;
    spi_byte_t     next_byte;
    accel_raw_t    x_raw;
    accel_raw_t    y_raw;
    accel_raw_t    z_raw;

    // Absolute value, saturated at 99; -128 gives 0x80 and saturates too
    function automatic accel_mag_t to_mag(input accel_raw_t raw);
        spi_byte_t mag;
        mag = raw[7] ? (~raw + 8'd1) : raw;
        return (mag > 8'd99) ? accel_mag_t'(99) : mag[6:0];
    endfunction

    always_comb begin
        next_byte = 8'h00;              // Dummy byte while data registers clock out
        case (byte_idx)
            3'd0: next_byte = (state == ST_CONFIG) ? CMD_WRITE : CMD_READ;
            3'd1: next_byte = (state == ST_CONFIG) ? REG_POWER_CTL : REG_XDATA;
            3'd2: next_byte = (state == ST_CONFIG) ? MEASURE_MODE : 8'h00;
            default: next_byte = 8'h00;
        endcase
    end

    assign last_byte   = (state == ST_CONFIG) ? (byte_idx == 3'd2) : (byte_idx == 3'd4);
    assign sample_tick = (sample_cnt == SW'(SAMPLE_CYCLES - 1));

    // Free-running sample period
    always_ff @(posedge CLK100MHZ or negedge rst_n) begin
        if (!rst_n) begin
            sample_cnt <= '0;
        end else if (sample_tick) begin
            sample_cnt <= '0;
        end else begin
            sample_cnt <= sample_cnt + SW'(1);
        end
    end

    always_ff @(posedge CLK100MHZ or negedge rst_n) begin
        if (!rst_n) begin
            state      <= ST_CONFIG;
            byte_idx   <= '0;
            in_flight  <= 1'b0;
            csn        <= 1'b1;
            byte_start <= 1'b0;
            tx_byte    <= '0;
            x_mag      <= '0;
            y_mag      <= '0;
            z_mag      <= '0;
        end else begin
            byte_start <= 1'b0;
            case (state)
                ST_CONFIG, ST_READ: begin
                    if (csn) begin
                        csn <= 1'b0;            // CS setup cycle before the first byte
                    end else if (!in_flight) begin
                        byte_start <= 1'b1;
                        tx_byte    <= next_byte;
                        in_flight  <= 1'b1;
                    end else if (byte_done) begin
                        in_flight <= 1'b0;
                        byte_idx  <= byte_idx + 3'd1;
                        if (last_byte) begin
                            csn      <= 1'b1;
                            byte_idx <= '0;
                            state    <= (state == ST_CONFIG) ? ST_GAP : ST_UPDATE;
                        end
                    end
                end
                ST_GAP:  state <= ST_WAIT;
                ST_WAIT: begin
                    if (sample_tick) begin
                        state <= ST_READ;
                    end
                end
                ST_UPDATE: begin
                    // All three axes change together
                    x_mag <= to_mag(x_raw);
                    y_mag <= to_mag(y_raw);
                    z_mag <= to_mag(z_raw);
                    state <= ST_WAIT;
                end
                default: state <= ST_WAIT;
            endcase
        end
    end

    // Axis bytes arrive as bytes 2..4 of the burst
    always_ff @(posedge CLK100MHZ) begin
        if (state == ST_READ && in_flight && byte_done) begin
            case (byte_idx)
                3'd2: x_raw <= rx_byte;
                3'd3: y_raw <= rx_byte;
                3'd4: z_raw <= rx_byte;
                default: ;
            endcase
        end
    end

    // CS stays low for the whole byte, up to the master's done pulse
    a_csn_framing: assert property (@(posedge CLK100MHZ) disable iff (!rst_n)
        byte_start |-> (!csn throughout byte_done[->1]));

endmodule

`default_nettype wire

/* accel_spi/accel_spi_master.sv */
`timescale 1ns/1ns
`default_nettype none

module accel_spi_master #(
    parameter int SCLK_HALF = 50
) (
    input  wire                  CLK100MHZ,
    input  wire                  rst_n,
    input  wire                  byte_start,
    input  wire accel_pkg::spi_byte_t tx_byte,
    input  wire                  miso,
    output logic                 byte_done,
    output accel_pkg::spi_byte_t rx_byte,
    output logic                 sclk,
    output logic                 mosi
);
    import accel_pkg::*;

    localparam int CW = (SCLK_HALF > 1) ? $clog2(SCLK_HALF) : 1;

    logic          busy;
    logic [CW-1:0] half_cnt;    // Clocks within the current SCLK half period
    logic [2:0]    bit_cnt;
    logic          half_end;
    spi_byte_t     tx_shift;
    spi_byte_t     rx_shift;

    assign half_end = busy && (half_cnt == CW'(SCLK_HALF - 1));

    // MSB first; the register empties to zero so MOSI idles low
    assign mosi    = tx_shift[7];
    assign rx_byte = rx_shift;

    always_ff @(posedge CLK100MHZ or negedge rst_n) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            half_cnt  <= '0;
            bit_cnt   <= '0;
            sclk      <= 1'b0;
            tx_shift  <= '0;
            byte_done <= 1'b0;
        end else begin
            byte_done <= 1'b0;
            if (byte_start && !busy) begin
                busy     <= 1'b1;
                half_cnt <= CW'(1);     // First low phase is one clock short, keeps 16*SCLK_HALF
                bit_cnt  <= '0;
                tx_shift <= tx_byte;
            end else if (busy) begin
                if (half_end) begin
                    half_cnt <= '0;
                    sclk     <= ~sclk;
                    if (sclk) begin
                        // Falling edge, present the next bit while SCLK is low
                        tx_shift <= {tx_shift[6:0], 1'b0};
                        bit_cnt  <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7) begin
                            busy      <= 1'b0;
                            byte_done <= 1'b1;   // rx_byte is complete here
                        end
                    end
                end else begin
                    half_cnt <= half_cnt + CW'(1);
                end
            end
        end
    end

    // Receive shifter samples MISO on the rising SCLK edge
    always_ff @(posedge CLK100MHZ) begin
        if (half_end && !sclk) begin
            rx_shift <= {rx_shift[6:0], miso};
        end
    end

    // The reader must wait for byte_done before the next byte
    a_no_overlap: assert property (@(posedge CLK100MHZ) disable iff (!rst_n)
        byte_start |-> !busy);

    // Fixed byte latency seen by the sequencer
    a_byte_latency: assert property (@(posedge CLK100MHZ) disable iff (!rst_n)
        byte_start |-> ##(16 * SCLK_HALF) byte_done);

endmodule

`default_nettype wire

/* bench/accel_vectors.txt */
// Raw axis bytes in hex, one sample per line
// Columns: X Y Z (two's complement)
00 00 00
05 0C 63
FF F4 9D
64 9C 7F
80 81 01
2A D6 0A
09 F7 13
37 C9 50
B0 4D 00
62 9E 1F

/* bench/adxl362_model.sv */
`timescale 1ns/1ns
`default_nettype none

module adxl362_model (
    input  wire                        csn,
    input  wire                        sclk,
    input  wire                        mosi,
    input  wire accel_pkg::accel_raw_t x_data,
    input  wire accel_pkg::accel_raw_t y_data,
    input  wire accel_pkg::accel_raw_t z_data,
    output logic                       miso,
    output logic                       proto_err,
    output int                         read_count
);
    import accel_pkg::*;

    spi_byte_t  rx_shift;
    spi_byte_t  rx_bytes [0:7];    // Bytes of the current transaction
    accel_raw_t out_bytes [0:2];   // Axis bytes latched when CS falls
    int         bit_cnt = 0;
    int         byte_cnt = 0;
    bit         in_frame = 1'b0;
    bit         configured = 1'b0;

    initial begin
        proto_err  = 1'b0;
        read_count = 0;
    end

    task automatic report_error(input string what);
        $display("SPI model: %s", what);
        proto_err = 1'b1;
    endtask

    // X, Y, Z go out MSB first as bytes 2..4 of a burst
    assign miso = (byte_cnt >= 2 && byte_cnt <= 4) ? out_bytes[byte_cnt - 2][7 - bit_cnt] : 1'b0;

    always @(negedge csn) begin
        in_frame     = 1'b1;
        bit_cnt      = 0;
        byte_cnt     = 0;
        out_bytes[0] = x_data;
        out_bytes[1] = y_data;
        out_bytes[2] = z_data;
    end

    // Mode 0, MOSI is stable on the rising edge
    always @(posedge sclk) begin
        if (csn) begin
            report_error("SCLK rose while CSN was high");
        end else begin
            rx_shift = {rx_shift[6:0], mosi};
            if (bit_cnt == 7) begin
                if (byte_cnt < 8) rx_bytes[byte_cnt] = rx_shift;
                byte_cnt = byte_cnt + 1;
                bit_cnt  = 0;
            end else begin
                bit_cnt = bit_cnt + 1;
            end
        end
    end

    always @(posedge csn) begin
        if (in_frame) begin
            in_frame = 1'b0;
            if (bit_cnt != 0) begin
                report_error("CSN rose in the middle of a byte");
            end else if (!configured) begin
                configured = 1'b1;
                if (byte_cnt != 3 || rx_bytes[0] !== CMD_WRITE
                    || rx_bytes[1] !== REG_POWER_CTL || rx_bytes[2] !== MEASURE_MODE)
                    report_error("wrong configuration, expected write of 0x02 to POWER_CTL");
            end else if (byte_cnt != 5 || rx_bytes[0] !== CMD_READ
                         || rx_bytes[1] !== REG_XDATA) begin
                report_error("read transaction is not a 5 byte burst read from XDATA");
            end else begin
                read_count = read_count + 1;
            end
        end
    end

endmodule

`default_nettype wire

/* bench/tb_accel_display.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_accel_display;
    import accel_pkg::*;

    localparam int SCLK_HALF     = 2;
    localparam int SAMPLE_CYCLES = 2000;
    localparam int DIGIT_CYCLES  = 20;
    localparam int MAX_SCANS     = 40;   // Spans two sample periods
    localparam int NUM_RANDOM    = 4;
    localparam seg_t BLANK       = 7'b111_1111;

    logic       CLK100MHZ;
    logic       rst_n;
    logic       acl_miso;
    logic       acl_sclk;
    logic       acl_mosi;
    logic       acl_csn;
    seg_t       seg;
    anode_t     digit;
    accel_raw_t x_data;
    accel_raw_t y_data;
    accel_raw_t z_data;
    logic       proto_err;
    int         read_count;

    accel_raw_t vec_mem [0:63];
    seg_t       font [0:9];          // Digit patterns with a as the MSB
    seg_t       expect_seg [0:7];
    anode_t     last_digit;
    int         dwell;
    int         changes;
    int         scan_idx;

    accel_display_top #(
        .SCLK_HALF    (SCLK_HALF),
        .SAMPLE_CYCLES(SAMPLE_CYCLES),
        .DIGIT_CYCLES (DIGIT_CYCLES)
    ) UUT (
        .CLK100MHZ(CLK100MHZ),
        .rst_n    (rst_n),
        .acl_miso (acl_miso),
        .acl_sclk (acl_sclk),
        .acl_mosi (acl_mosi),
        .acl_csn  (acl_csn),
        .seg      (seg),
        .digit    (digit)
    );

    adxl362_model u_model (
        .csn       (acl_csn),
        .sclk      (acl_sclk),
        .mosi      (acl_mosi),
        .x_data    (x_data),
        .y_data    (y_data),
        .z_data    (z_data),
        .miso      (acl_miso),
        .proto_err (proto_err),
        .read_count(read_count)
    );

    always #5 CLK100MHZ = ~CLK100MHZ;

    task automatic fail_now();
        $display("SOME TESTS FAILED");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_seg(input string name, input seg_t exp, input seg_t act);
        if (act !== exp) begin
            $display("ERR %s expected %b actual %b", name, exp, act);
            fail_now();
        end
    endtask

    task automatic check_digit(input string name, input anode_t exp, input anode_t act);
        if (act !== exp) begin
            $display("ERR %s expected %h actual %h", name, exp, act);
            fail_now();
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("ERR %s expected %0d actual %0d", name, exp, act);
            fail_now();
        end
    endtask

    // Absolute value of the signed sample limited to two digits
    function automatic int display_value(input accel_raw_t raw);
        int value;
        value = int'($signed(raw));
        if (value < 0) value = -value;
        return (value > 99) ? 99 : value;
    endfunction

    task automatic build_expected(input accel_raw_t x, input accel_raw_t y, input accel_raw_t z);
        int xv;
        int yv;
        int zv;
        xv = display_value(x);
        yv = display_value(y);
        zv = display_value(z);
        expect_seg[0] = font[zv % 10];
        expect_seg[1] = font[zv / 10];
        expect_seg[2] = BLANK;
        expect_seg[3] = font[yv % 10];
        expect_seg[4] = font[yv / 10];
        expect_seg[5] = BLANK;
        expect_seg[6] = font[xv % 10];
        expect_seg[7] = font[xv / 10];
    endtask

    task automatic wait_for_anode(input int idx);
        int cycles;
        cycles = 0;
        @(negedge CLK100MHZ);
        while (digit !== ~(anode_t'(1) << idx)) begin
            if (cycles > 16 * DIGIT_CYCLES) begin
                $display("Timeout: anode of digit %0d never became active", idx);
                fail_now();
            end else begin
                cycles++;
                @(negedge CLK100MHZ);
            end
        end
    endtask

    // One pass over digits 0..7 where strict mode fails on the first mismatch
    task automatic scan_display(input string name, input bit strict, output bit all_match);
        all_match = 1'b1;
        for (int i = 0; i < 8; i++) begin
            wait_for_anode(i);
            if (strict)
                check_seg($sformatf("%s digit %0d", name, i), expect_seg[i], seg);
            else if (seg !== expect_seg[i])
                all_match = 1'b0;
        end
    endtask

    task automatic show_vector(input string name, input accel_raw_t x, input accel_raw_t y,
                               input accel_raw_t z);
        bit matched;
        int scans;
        int reads_needed;
        int reads_before;
        x_data = x;
        y_data = y;
        z_data = z;
        // A burst already under way still carries the previous triple
        reads_needed = read_count + ((acl_csn === 1'b1) ? 1 : 2);
        build_expected(x, y, z);
        matched = 1'b0;
        scans   = 0;
        while (!matched && scans < MAX_SCANS - 1) begin
            reads_before = read_count;
            scan_display(name, 1'b0, matched);
            if (reads_before < reads_needed) matched = 1'b0;
            scans++;
        end
        if (!matched && read_count < reads_needed) begin
            $display("Timeout: no burst read picked up the data of %s", name);
            fail_now();
        end else if (!matched) begin
            scan_display(name, 1'b1, matched);
        end
    endtask

    // Anode order and dwell sampled away from the active edge
    always @(negedge CLK100MHZ) begin
        if (!rst_n) begin
            changes    = 0;
            dwell      = 0;
            scan_idx   = 0;
            last_digit = digit;
        end else if (digit !== last_digit) begin
            if (changes > 0) check_count("anode dwell", DIGIT_CYCLES, dwell);
            scan_idx = (scan_idx + 1) % 8;
            check_digit("anode order", ~(anode_t'(1) << scan_idx), digit);
            changes++;
            dwell      = 1;
            last_digit = digit;
        end else begin
            dwell++;
        end
    end

    always @(posedge proto_err) begin
        $display("The SPI model saw a bad transaction");
        fail_now();
    end

    initial begin : main_seq
        int unsigned seed_value;
        int          n;
        bit          matched;
        CLK100MHZ = 1'b0;
        rst_n     = 1'b0;
        x_data    = '0;
        y_data    = '0;
        z_data    = '0;
        seed_value = $urandom(92591);
        font[0] = 7'b000_0001;
        font[1] = 7'b100_1111;
        font[2] = 7'b001_0010;
        font[3] = 7'b000_0110;
        font[4] = 7'b100_1100;
        font[5] = 7'b010_0100;
        font[6] = 7'b010_0000;
        font[7] = 7'b000_1111;
        font[8] = 7'b000_0000;
        font[9] = 7'b000_0100;
        $readmemh("bench/accel_vectors.txt", vec_mem);

        repeat (15) @(negedge CLK100MHZ);
        if (acl_csn !== 1'b1 || acl_sclk !== 1'b0 || acl_mosi !== 1'b0) begin
            $display("SPI pins are not idle during reset");
            fail_now();
        end
        check_digit("reset anode", 8'hFE, digit);
        @(negedge CLK100MHZ);
        rst_n = 1'b1;

        // Display shows zeros until the first sample
        build_expected(8'h00, 8'h00, 8'h00);
        scan_display("reset", 1'b1, matched);

        n = 0;
        while (n + 2 < 64 && !$isunknown(vec_mem[n])) begin
            show_vector($sformatf("vector %0d", n / 3), vec_mem[n], vec_mem[n + 1],
                        vec_mem[n + 2]);
            n += 3;
        end
        for (int i = 0; i < NUM_RANDOM; i++) begin
            show_vector($sformatf("random %0d", i), accel_raw_t'($urandom),
                        accel_raw_t'($urandom), accel_raw_t'($urandom));
        end

        if (n == 0 || read_count == 0) begin
            $display("No vectors were loaded or no burst read was seen");
            fail_now();
        end else begin
            $display("ALL TESTS PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* common/accel_pkg.sv */
`default_nettype none

package accel_pkg;

    // Widths that carry a meaning across the design
    typedef logic [7:0] spi_byte_t;    // One byte on the SPI bus
    typedef logic [7:0] accel_raw_t;   // Signed axis sample, two's complement
    typedef logic [6:0] accel_mag_t;   // Display magnitude 0..99
    typedef logic [3:0] bcd_t;         // One decimal digit
    typedef logic [6:0] seg_t;         // Segments a..g, active low
    typedef logic [7:0] anode_t;       // Digit enables, active low

    // ADXL362 command bytes
    localparam spi_byte_t CMD_WRITE = 8'h0A;
    localparam spi_byte_t CMD_READ  = 8'h0B;

    // Register map, only what the reader touches
    localparam spi_byte_t REG_POWER_CTL = 8'h2D;
    localparam spi_byte_t REG_XDATA     = 8'h08;   // X, Y, Z follow in one burst

    // POWER_CTL value for measurement mode
    localparam spi_byte_t MEASURE_MODE = 8'h02;

endpackage

`default_nettype wire

/* flist.f */
common/accel_pkg.sv
accel_spi/accel_spi_master.sv
accel_spi/accel_reader.sv
rtl/seg7_control.sv
rtl/accel_display_top.sv
bench/adxl362_model.sv
bench/tb_accel_display.sv

/* rtl/accel_display_top.sv */
`timescale 1ns/1ns
`default_nettype none

module accel_display_top #(
    parameter int SCLK_HALF     = 50,           // 1 MHz SCLK from 100 MHz
    parameter int SAMPLE_CYCLES = 10_000_000,   // 10 samples per second
    parameter int DIGIT_CYCLES  = 100_000       // 1 ms per digit
) (
    input  wire                    CLK100MHZ,
    input  wire                    rst_n,
    input  wire                    acl_miso,
    output wire                    acl_sclk,
    output wire                    acl_mosi,
    output wire                    acl_csn,
    output wire accel_pkg::seg_t   seg,
    output wire accel_pkg::anode_t digit
);
    import accel_pkg::*;

    logic       byte_start;
    logic       byte_done;
    spi_byte_t  tx_byte;
    spi_byte_t  rx_byte;
    accel_mag_t x_mag;
    accel_mag_t y_mag;
    accel_mag_t z_mag;

    accel_reader #(
        .SAMPLE_CYCLES(SAMPLE_CYCLES)
    ) u_reader (
        .CLK100MHZ (CLK100MHZ),
        .rst_n     (rst_n),
        .byte_done (byte_done),
        .rx_byte   (rx_byte),
        .byte_start(byte_start),
        .tx_byte   (tx_byte),
        .csn       (acl_csn),
        .x_mag     (x_mag),
        .y_mag     (y_mag),
        .z_mag     (z_mag)
    );

    accel_spi_master #(
        .SCLK_HALF(SCLK_HALF)
    ) u_spi (
        .CLK100MHZ (CLK100MHZ),
        .rst_n     (rst_n),
        .byte_start(byte_start),
        .tx_byte   (tx_byte),
        .miso      (acl_miso),
        .byte_done (byte_done),
        .rx_byte   (rx_byte),
        .sclk      (acl_sclk),
        .mosi      (acl_mosi)
    );

    seg7_control #(
        .DIGIT_CYCLES(DIGIT_CYCLES)
    ) u_seg7 (
        .CLK100MHZ(CLK100MHZ),
        .rst_n    (rst_n),
        .x_mag    (x_mag),
        .y_mag    (y_mag),
        .z_mag    (z_mag),
        .seg      (seg),
        .digit    (digit)
    );

endmodule

`default_nettype wire

/* rtl/seg7_control.sv */
`timescale 1ns/1ns
`default_nettype none

module seg7_control #(
    parameter int DIGIT_CYCLES = 100_000
) (
    input  wire                   CLK100MHZ,
    input  wire                   rst_n,
    input  wire accel_pkg::accel_mag_t x_mag,
    input  wire accel_pkg::accel_mag_t y_mag,
    input  wire accel_pkg::accel_mag_t z_mag,
    output accel_pkg::seg_t       seg,
    output accel_pkg::anode_t     digit
);
    import accel_pkg::*;

    // Segment patterns with a as the MSB
    localparam seg_t ZERO  = 7'b000_0001;
    localparam seg_t ONE   = 7'b100_1111;
    localparam seg_t TWO   = 7'b001_0010;
    localparam seg_t THREE = 7'b000_0110;
    localparam seg_t FOUR  = 7'b100_1100;
    localparam seg_t FIVE  = 7'b010_0100;
    localparam seg_t SIX   = 7'b010_0000;
    localparam seg_t SEVEN = 7'b000_1111;
    localparam seg_t EIGHT = 7'b000_0000;
    localparam seg_t NINE  = 7'b000_0100;
    localparam seg_t BLANK = 7'b111_1111;

    localparam int TW = (DIGIT_CYCLES > 1) ? $clog2(DIGIT_CYCLES) : 1;

    logic [TW-1:0] digit_timer;    // Clocks the current digit has been lit
    logic [2:0]    digit_select;
    bcd_t          x_tens;
    bcd_t          x_ones;
    bcd_t          y_tens;
    bcd_t          y_ones;
    bcd_t          z_tens;
    bcd_t          z_ones;

    function automatic seg_t decode(input bcd_t value);
        case (value)
            4'd0: return ZERO;
            4'd1: return ONE;
            4'd2: return TWO;
            4'd3: return THREE;
            4'd4: return FOUR;
            4'd5: return FIVE;
            4'd6: return SIX;
            4'd7: return SEVEN;
            4'd8: return EIGHT;
            4'd9: return NINE;
            default: return BLANK;
        endcase
    endfunction

    // Binary to BCD for magnitudes up to 99
    assign x_tens = bcd_t'(x_mag / 7'd10);
    assign x_ones = bcd_t'(x_mag % 7'd10);
    assign y_tens = bcd_t'(y_mag / 7'd10);
    assign y_ones = bcd_t'(y_mag % 7'd10);
    assign z_tens = bcd_t'(z_mag / 7'd10);
    assign z_ones = bcd_t'(z_mag % 7'd10);

    // Refresh timer advancing one digit per DIGIT_CYCLES
    always_ff @(posedge CLK100MHZ or negedge rst_n) begin
        if (!rst_n) begin
            digit_timer  <= '0;
            digit_select <= '0;
        end else if (digit_timer == TW'(DIGIT_CYCLES - 1)) begin
            digit_timer  <= '0;
            digit_select <= digit_select + 3'd1;   // Wraps 7 -> 0
        end else begin
            digit_timer <= digit_timer + TW'(1);
        end
    end

    assign digit = ~(anode_t'(1) << digit_select);

    // Z, blank, Y, blank and X from right to left
    always_comb begin
        case (digit_select)
            3'd0:    seg = decode(z_ones);
            3'd1:    seg = decode(z_tens);
            3'd2:    seg = BLANK;
            3'd3:    seg = decode(y_ones);
            3'd4:    seg = decode(y_tens);
            3'd5:    seg = BLANK;
            3'd6:    seg = decode(x_ones);
            default: seg = decode(x_tens);
        endcase
    end

    // One anode low at a time and passed to the next digit after a full dwell
    a_one_anode: assert property (@(posedge CLK100MHZ) disable iff (!rst_n)
        $onehot(~digit) && (($past(digit_timer) == TW'(DIGIT_CYCLES - 1)) ?
            (digit == {$past(digit[6:0]), $past(digit[7])}) : $stable(digit)));

endmodule

`default_nettype wire
